//--- verilog.f
src/radio_cfg_pkg.sv
src/slot_regs_pkg.sv
src/db_gpio_atr.sv
src/apb_slot_decoder.sv
src/slot_control.sv
src/fp_gpio_mux.sv
src/slot_core_top.sv
dv/slot_core_checker.sv
dv/tb_slot_core.sv

//--- dv/tb_slot_core.sv
`timescale 1ns/100ps

module tb_slot_core;

   import radio_cfg_pkg::*;
   import slot_regs_pkg::*;

   localparam int DB_W       = DB_GPIO_W_DEF;
   localparam int FP_W       = FP_GPIO_W_DEF;
   localparam int CLK_PERIOD = 4;
   localparam int ITERS      = 24;
   // reset, 100 two-cycle transfers, then per iteration: 2 + 2 + 5 + 15 cycles
   localparam int TEST_CYCLES = 5 + 2 * 100 + ITERS * 24;

   logic                                          radio_clk = 1'b0;
   logic                                          i_rst_n;
   logic                                          i_psel;
   logic                                          i_penable;
   logic                                          i_pwrite;
   logic [APB_ADDR_W-1:0]                         i_paddr;
   logic [APB_DATA_W-1:0]                         i_pwdata;
   logic [APB_DATA_W-1:0]                         o_prdata;
   logic                                          o_pready;
   logic                                          o_pslverr;
   logic [NUM_SLOTS*CHANS_PER_SLOT-1:0]           i_rx_running;
   logic [NUM_SLOTS*CHANS_PER_SLOT-1:0]           i_tx_running;
   logic [NUM_SLOTS-1:0][DB_W-1:0]                i_db_gpio_in;
   logic [NUM_SLOTS-1:0][DB_W-1:0]                o_db_gpio_out;
   logic [NUM_SLOTS-1:0][DB_W-1:0]                o_db_gpio_ddr;
   logic [FP_W-1:0]                               i_fp_gpio_in;
   logic [FP_W-1:0]                               o_fp_gpio_out;
   logic [FP_W-1:0]                               o_fp_gpio_ddr;
   logic [NUM_SLOTS-1:0][LED_W-1:0]               o_radio_led;
   logic [NUM_SLOTS-1:0][APB_DATA_W-1:0]          i_misc_in;
   logic [NUM_SLOTS-1:0][APB_DATA_W-1:0]          o_misc_out;

   // reference model, register mirror
   logic [DB_W-1:0]       m_db [NUM_SLOTS][5];   // atr words 0-3, ddr at 4
   logic [FP_W-1:0]       m_fp [NUM_SLOTS][5];
   logic [APB_DATA_W-1:0] m_misc [NUM_SLOTS];
   logic [2*FP_W-1:0]     m_src;                 // 2 bits per panel pin
   integer                seed = 50;

   always #(CLK_PERIOD / 2) radio_clk = ~radio_clk;

   slot_core_top #(.DB_GPIO_W(DB_W), .FP_GPIO_W(FP_W)) uut (.*);

   slot_core_checker #(.DB_W(DB_W), .FP_W(FP_W)) chk (
      .i_db_gpio_out (o_db_gpio_out),
      .i_db_gpio_ddr (o_db_gpio_ddr),
      .i_radio_led   (o_radio_led),
      .i_misc_out    (o_misc_out),
      .i_fp_gpio_out (o_fp_gpio_out),
      .i_fp_gpio_ddr (o_fp_gpio_ddr)
   );

   // --------------------------------------------------
   // model rules
   // --------------------------------------------------
   // state bit 1 = any tx channel, bit 0 = any rx channel
   function automatic logic [1:0] state_of(input int s);
      logic rx;
      logic tx;
      rx = |i_rx_running[s*CHANS_PER_SLOT +: CHANS_PER_SLOT];
      tx = |i_tx_running[s*CHANS_PER_SLOT +: CHANS_PER_SLOT];
      return {tx, rx};
   endfunction

   function automatic logic [LED_W-1:0] led_of(input logic [1:0] st);
      return {st[0] & ~st[1], st[1], st[0] & st[1]};   // rx, txrx_tx, txrx_rx
   endfunction

   function automatic logic [APB_DATA_W-1:0] exp_read(input int s, input int off);
      logic [APB_DATA_W-1:0] v;
      v = '0;
      if (off <= 4) begin
         v = m_db[s][off];
      end else if (off <= 8) begin
         v = m_fp[s][off-5];
      end else if (off == 9) begin
         v = {i_fp_gpio_in, m_fp[s][4]};   // panel pins above ddr
      end else if (off == 10) begin
         v = m_misc[s];
      end else if (off == 11) begin
         v = i_db_gpio_in[s];
      end else begin
         v = i_misc_in[s];   // held for more than the input stage
      end
      return v;
   endfunction

   task automatic model_write(input int s, input int off, input logic [APB_DATA_W-1:0] d);
      if (off <= 4) begin
         m_db[s][off] = d[DB_W-1:0];
      end else if (off <= 9) begin
         m_fp[s][off-5] = d[FP_W-1:0];
      end else if (off == 10) begin
         m_misc[s] = d;
      end
   endtask

   function automatic logic [APB_ADDR_W-1:0] slot_addr(input int s, input int off);
      logic [APB_ADDR_W-1:0] a;
      a = '0;
      a[SLOT_SEL_BIT] = s[0];
      a[OFFSET_MSB:OFFSET_LSB] = off[3:0];
      return a;
   endfunction

   function automatic logic [APB_ADDR_W-1:0] global_addr(input int off);
      logic [APB_ADDR_W-1:0] a;
      a = '0;
      a[GLOBAL_BIT] = 1'b1;
      a[OFFSET_MSB:OFFSET_LSB] = off[3:0];
      return a;
   endfunction

   // --------------------------------------------------
   // apb transfers, entered 1 ns after an edge
   // --------------------------------------------------
   task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                           input logic [APB_DATA_W-1:0] wdata,
                           output logic [APB_DATA_W-1:0] rdata, output logic err);
      i_psel    = 1'b1;   // setup phase
      i_penable = 1'b0;
      i_pwrite  = wr;
      i_paddr   = addr;
      i_pwdata  = wdata;
      @(posedge radio_clk);
      #1;
      i_penable = 1'b1;   // access phase
      #1;
      if (o_pready !== 1'b1) begin
         chk.report_problem("pready stayed low in the access phase");
      end
      rdata = o_prdata;
      err   = o_pslverr;
      @(posedge radio_clk);
      #1;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic write_reg(input int s, input int off, input logic [APB_DATA_W-1:0] d);
      logic [APB_DATA_W-1:0] rd;
      logic                  err;
      apb_xfer(1'b1, slot_addr(s, off), d, rd, err);
      chk.compare($sformatf("slot%0d off%0d write pslverr", s, off), 1'b0, err);
      model_write(s, off, d);
   endtask

   task automatic read_check(input int s, input int off);
      logic [APB_DATA_W-1:0] rd;
      logic                  err;
      apb_xfer(1'b0, slot_addr(s, off), '0, rd, err);
      chk.compare($sformatf("slot%0d off%0d pslverr", s, off), 1'b0, err);
      chk.compare($sformatf("slot%0d off%0d prdata", s, off), exp_read(s, off), rd);
   endtask

   task automatic write_src(input logic [APB_DATA_W-1:0] d);
      logic [APB_DATA_W-1:0] rd;
      logic                  err;
      apb_xfer(1'b1, global_addr(FP_SRC_OFFSET), d, rd, err);
      chk.compare("fp_src write pslverr", 1'b0, err);
      m_src = d[2*FP_W-1:0];
   endtask

   task automatic read_src_check();
      logic [APB_DATA_W-1:0] rd;
      logic                  err;
      apb_xfer(1'b0, global_addr(FP_SRC_OFFSET), '0, rd, err);
      chk.compare("fp_src pslverr", 1'b0, err);
      chk.compare("fp_src prdata", m_src, rd);
   endtask

   // bad access, error with zero data
   task automatic bad_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr);
      logic [APB_DATA_W-1:0] rd;
      logic                  err;
      apb_xfer(wr, addr, $random(seed), rd, err);
      chk.compare($sformatf("addr %h pslverr", addr), 1'b1, err);
      chk.compare($sformatf("addr %h prdata", addr), '0, rd);
   endtask

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge radio_clk);
      #1;
   endtask

   task automatic drive_flags();
      i_rx_running = $random(seed);
      i_tx_running = $random(seed);
   endtask

   task automatic check_slots(input logic do_gpio, input logic do_led);
      logic [1:0] st;
      for (int s = 0; s < NUM_SLOTS; s++) begin
         st = state_of(s);
         if (do_gpio) chk.check_db(s, m_db[s][st], m_db[s][4]);
         if (do_led) chk.check_led(s, led_of(st));
      end
   endtask

   task automatic check_panel();
      logic [FP_W-1:0] e_out;
      logic [FP_W-1:0] e_ddr;
      int              sel;
      for (int p = 0; p < FP_W; p++) begin
         sel = (m_src[2*p +: 2] != 2'b00) ? 1 : 0;   // nonzero field picks slot 1
         e_out[p] = m_fp[sel][state_of(sel)][p];
         e_ddr[p] = m_fp[sel][4][p];
      end
      chk.check_fp(e_out, e_ddr);
   endtask

   task automatic verify_all_regs();
      for (int s = 0; s < NUM_SLOTS; s++) begin
         for (int off = 0; off <= 12; off++) read_check(s, off);
      end
      read_src_check();
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      i_rst_n      = 1'b0;
      i_psel       = 1'b0;
      i_penable    = 1'b0;
      i_pwrite     = 1'b0;
      i_paddr      = '0;
      i_pwdata     = '0;
      i_rx_running = '0;
      i_tx_running = '0;
      i_db_gpio_in = '0;
      i_fp_gpio_in = '0;
      i_misc_in    = '0;
      m_src        = '0;
      for (int s = 0; s < NUM_SLOTS; s++) begin
         m_misc[s] = '0;
         for (int k = 0; k < 5; k++) begin
            m_db[s][k] = '0;
            m_fp[s][k] = '0;
         end
      end
      repeat (4) @(posedge radio_clk);
      #1;
      i_rst_n = 1'b1;

      chk.start_test("reset_state");   // everything cleared, state idle
      check_slots(1'b1, 1'b1);
      check_panel();
      for (int s = 0; s < NUM_SLOTS; s++) chk.check_misc(s, '0);
      chk.end_test();

      chk.start_test("reg_round_trip");
      for (int s = 0; s < NUM_SLOTS; s++) begin
         for (int off = 0; off <= 10; off++) begin
            write_reg(s, off, $random(seed));
            read_check(s, off);
         end
      end
      write_src($random(seed));
      read_src_check();
      chk.end_test();

      chk.start_test("atr_gpio");
      repeat (ITERS) begin
         drive_flags();
         wait_cycles(2);   // state, then output register
         check_slots(1'b1, 1'b0);
      end
      chk.end_test();

      chk.start_test("leds");
      repeat (ITERS) begin
         drive_flags();
         wait_cycles(2);
         check_slots(1'b0, 1'b1);
      end
      chk.end_test();

      chk.start_test("fp_mux");
      repeat (ITERS) begin
         write_src($random(seed));
         drive_flags();
         wait_cycles(3);   // two sync flops plus output, or slot path plus output
         check_panel();
      end
      chk.end_test();

      chk.start_test("misc_readback");
      repeat (ITERS) begin
         for (int s = 0; s < NUM_SLOTS; s++) begin
            i_misc_in[s]    = $random(seed);
            i_db_gpio_in[s] = $random(seed);
         end
         i_fp_gpio_in = $random(seed);
         write_reg($random(seed) & 1, int'(MISC_OUT), $random(seed));
         wait_cycles(1);
         for (int s = 0; s < NUM_SLOTS; s++) begin
            chk.check_misc(s, m_misc[s]);
            read_check(s, int'(MISC_IN_RB));
            read_check(s, int'(DB_GPIO_RB));
            read_check(s, int'(FP_DDR));
         end
      end
      chk.end_test();

      chk.start_test("bad_access");
      for (int s = 0; s < NUM_SLOTS; s++) begin
         for (int off = 13; off <= 15; off++) bad_xfer(1'b0, slot_addr(s, off));
         bad_xfer(1'b1, slot_addr(s, int'(DB_GPIO_RB)));
         bad_xfer(1'b1, slot_addr(s, int'(MISC_IN_RB)));
      end
      for (int off = 1; off <= 15; off++) bad_xfer(1'b0, global_addr(off));
      bad_xfer(1'b1, global_addr(3));
      bad_xfer(1'b1, slot_addr(1, 14));
      verify_all_regs();   // nothing may have moved
      chk.end_test();

      chk.print_totals();
      if (chk.n_failed == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // watchdog, twice the expected run length
   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", 2 * TEST_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule : tb_slot_core

//--- dv/slot_core_checker.sv
`timescale 1ns/100ps

module slot_core_checker #(
   parameter int DB_W = 32,
   parameter int FP_W = 12
) (
   input logic [radio_cfg_pkg::NUM_SLOTS-1:0][DB_W-1:0]                     i_db_gpio_out,
   input logic [radio_cfg_pkg::NUM_SLOTS-1:0][DB_W-1:0]                     i_db_gpio_ddr,
   input logic [radio_cfg_pkg::NUM_SLOTS-1:0][radio_cfg_pkg::LED_W-1:0]      i_radio_led,
   input logic [radio_cfg_pkg::NUM_SLOTS-1:0][radio_cfg_pkg::APB_DATA_W-1:0] i_misc_out,
   input logic [FP_W-1:0]                                                   i_fp_gpio_out,
   input logic [FP_W-1:0]                                                   i_fp_gpio_ddr
);

   import radio_cfg_pkg::*;

   string test_name = "none";
   int    test_errs = 0;   // mismatches in the running test
   int    n_passed  = 0;
   int    n_failed  = 0;

   // --------------------------------------------------
   // test bookkeeping
   // --------------------------------------------------
   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      if (test_errs == 0) begin
         n_passed++;
         $display("test %s: pass", test_name);
      end else begin
         n_failed++;
         $display("test %s: fail, %0d mismatches", test_name, test_errs);
      end
   endtask

   task automatic compare(input string what, input logic [APB_DATA_W-1:0] exp,
                          input logic [APB_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
         test_errs++;
      end
   endtask

   // protocol trouble, no value to show
   task automatic report_problem(input string msg);
      $display("test %s: %s", test_name, msg);
      test_errs++;
   endtask

   // --------------------------------------------------
   // dut port checks, called at stable points
   // --------------------------------------------------
   task automatic check_db(input int s, input logic [DB_W-1:0] exp_out,
                           input logic [DB_W-1:0] exp_ddr);
      compare($sformatf("slot%0d db_gpio_out", s), exp_out, i_db_gpio_out[s]);
      compare($sformatf("slot%0d db_gpio_ddr", s), exp_ddr, i_db_gpio_ddr[s]);
   endtask

   task automatic check_led(input int s, input logic [LED_W-1:0] exp);
      compare($sformatf("slot%0d radio_led", s), exp, i_radio_led[s]);
   endtask

   task automatic check_misc(input int s, input logic [APB_DATA_W-1:0] exp);
      compare($sformatf("slot%0d misc_out", s), exp, i_misc_out[s]);
   endtask

   task automatic check_fp(input logic [FP_W-1:0] exp_out, input logic [FP_W-1:0] exp_ddr);
      compare("fp_gpio_out", exp_out, i_fp_gpio_out);
      compare("fp_gpio_ddr", exp_ddr, i_fp_gpio_ddr);
   endtask

   task automatic print_totals();
      $display("tests run %0d, passed %0d, failed %0d", n_passed + n_failed, n_passed,
               n_failed);
   endtask

endmodule : slot_core_checker

//--- src/slot_core_top.sv
`timescale 1ns/100ps

module slot_core_top #(
   parameter int DB_GPIO_W = radio_cfg_pkg::DB_GPIO_W_DEF,
   parameter int FP_GPIO_W = radio_cfg_pkg::FP_GPIO_W_DEF
) (
   input  logic                                 radio_clk,
   input  logic                                 i_rst_n,
   // apb slave
   input  logic                                 i_psel,
   input  logic                                 i_penable,
   input  logic                                 i_pwrite,
   input  logic [radio_cfg_pkg::APB_ADDR_W-1:0] i_paddr,
   input  logic [radio_cfg_pkg::APB_DATA_W-1:0] i_pwdata,
   output logic [radio_cfg_pkg::APB_DATA_W-1:0] o_prdata,
   output logic                                 o_pready,
   output logic                                 o_pslverr,
   // channel run flags, slot s owns bits s*2 +: 2
   input  logic [radio_cfg_pkg::NUM_SLOTS*radio_cfg_pkg::CHANS_PER_SLOT-1:0] i_rx_running,
   input  logic [radio_cfg_pkg::NUM_SLOTS*radio_cfg_pkg::CHANS_PER_SLOT-1:0] i_tx_running,
   // daughterboard pins
   input  logic [radio_cfg_pkg::NUM_SLOTS-1:0][DB_GPIO_W-1:0] i_db_gpio_in,
   output logic [radio_cfg_pkg::NUM_SLOTS-1:0][DB_GPIO_W-1:0] o_db_gpio_out,
   output logic [radio_cfg_pkg::NUM_SLOTS-1:0][DB_GPIO_W-1:0] o_db_gpio_ddr,
   // front panel
   input  logic [FP_GPIO_W-1:0]                 i_fp_gpio_in,
   output logic [FP_GPIO_W-1:0]                 o_fp_gpio_out,
   output logic [FP_GPIO_W-1:0]                 o_fp_gpio_ddr,
   // leds and misc
   output logic [radio_cfg_pkg::NUM_SLOTS-1:0][radio_cfg_pkg::LED_W-1:0]      o_radio_led,
   input  logic [radio_cfg_pkg::NUM_SLOTS-1:0][radio_cfg_pkg::APB_DATA_W-1:0] i_misc_in,
   output logic [radio_cfg_pkg::NUM_SLOTS-1:0][radio_cfg_pkg::APB_DATA_W-1:0] o_misc_out
);

   import radio_cfg_pkg::*;
   import slot_regs_pkg::*;

   logic [NUM_SLOTS-1:0][APB_DATA_W-1:0] w_slot_rdata;
   logic [NUM_SLOTS-1:0]                 w_slot_wr_stb;
   slot_reg_t                            w_reg;
   logic [APB_DATA_W-1:0]                w_wdata;
   logic                                 w_fp_src_wr_stb;
   logic [APB_DATA_W-1:0]                w_fp_src_rdata;
   logic [NUM_SLOTS-1:0][FP_GPIO_W-1:0]  w_slot_fp_out;
   logic [NUM_SLOTS-1:0][FP_GPIO_W-1:0]  w_slot_fp_ddr;

   // --------------------------------------------------
   // register access
   // --------------------------------------------------
   apb_slot_decoder u_decoder (
      .radio_clk       (radio_clk),
      .i_rst_n         (i_rst_n),
      .i_psel          (i_psel),
      .i_penable       (i_penable),
      .i_pwrite        (i_pwrite),
      .i_paddr         (i_paddr),
      .i_pwdata        (i_pwdata),
      .o_prdata        (o_prdata),
      .o_pready        (o_pready),
      .o_pslverr       (o_pslverr),
      .i_slot_rdata    (w_slot_rdata),
      .o_slot_wr_stb   (w_slot_wr_stb),
      .o_reg           (w_reg),
      .o_wdata         (w_wdata),
      .i_fp_src_rdata  (w_fp_src_rdata),
      .o_fp_src_wr_stb (w_fp_src_wr_stb)
   );

   // --------------------------------------------------
   // one control block per slot
   // --------------------------------------------------
   for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
      slot_control #(
         .DB_GPIO_W (DB_GPIO_W),
         .FP_GPIO_W (FP_GPIO_W)
      ) u_slot (
         .radio_clk     (radio_clk),
         .i_rst_n       (i_rst_n),
         .i_wr_stb      (w_slot_wr_stb[g]),
         .i_reg         (w_reg),
         .i_wdata       (w_wdata),
         .o_rdata       (w_slot_rdata[g]),
         .i_rx_running  (i_rx_running[g*CHANS_PER_SLOT +: CHANS_PER_SLOT]),
         .i_tx_running  (i_tx_running[g*CHANS_PER_SLOT +: CHANS_PER_SLOT]),
         .i_db_gpio_in  (i_db_gpio_in[g]),
         .o_db_gpio_out (o_db_gpio_out[g]),
         .o_db_gpio_ddr (o_db_gpio_ddr[g]),
         .i_fp_gpio_in  (i_fp_gpio_in),      // every slot sees the panel pins
         .o_fp_gpio_out (w_slot_fp_out[g]),
         .o_fp_gpio_ddr (w_slot_fp_ddr[g]),
         .o_led         (o_radio_led[g]),
         .i_misc_in     (i_misc_in[g]),
         .o_misc_out    (o_misc_out[g])
      );
   end

   // front-panel source select
   fp_gpio_mux #(.FP_GPIO_W(FP_GPIO_W)) u_fp_mux (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_wr_stb      (w_fp_src_wr_stb),
      .i_wdata       (w_wdata),
      .o_src_rdata   (w_fp_src_rdata),
      .i_slot_fp_out (w_slot_fp_out),
      .i_slot_fp_ddr (w_slot_fp_ddr),
      .o_fp_gpio_out (o_fp_gpio_out),
      .o_fp_gpio_ddr (o_fp_gpio_ddr)
   );

endmodule : slot_core_top

//--- src/fp_gpio_mux.sv
`timescale 1ns/100ps

module fp_gpio_mux #(
   parameter int FP_GPIO_W = 12
) (
   input  logic                                 radio_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_wr_stb,
   input  logic [radio_cfg_pkg::APB_DATA_W-1:0] i_wdata,
   output logic [radio_cfg_pkg::APB_DATA_W-1:0] o_src_rdata,
   input  logic [radio_cfg_pkg::NUM_SLOTS-1:0][FP_GPIO_W-1:0] i_slot_fp_out,
   input  logic [radio_cfg_pkg::NUM_SLOTS-1:0][FP_GPIO_W-1:0] i_slot_fp_ddr,
   output logic [FP_GPIO_W-1:0]                 o_fp_gpio_out,
   output logic [FP_GPIO_W-1:0]                 o_fp_gpio_ddr
);

   import radio_cfg_pkg::*;

   logic [2*FP_GPIO_W-1:0] r_fp_src;    // 2 bits per pin
   logic [2*FP_GPIO_W-1:0] r_src_meta;  // sync stage 1
   logic [2*FP_GPIO_W-1:0] r_src_sync;  // sync stage 2

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         r_fp_src   <= '0;
         r_src_meta <= '0;
         r_src_sync <= '0;
      end else begin
         if (i_wr_stb) begin
            r_fp_src <= (2*FP_GPIO_W)'(i_wdata);
         end
         r_src_meta <= r_fp_src;
         r_src_sync <= r_src_meta;
      end
   end

   assign o_src_rdata = APB_DATA_W'(r_fp_src);

   // --------------------------------------------------
   // per-pin source select, 0 = slot 0, else slot 1
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         for (int p = 0; p < FP_GPIO_W; p++) begin
            o_fp_gpio_out[p] <= i_slot_fp_out[|r_src_sync[2*p +: 2]][p];
            o_fp_gpio_ddr[p] <= i_slot_fp_ddr[|r_src_sync[2*p +: 2]][p];
         end
      end
   end

endmodule : fp_gpio_mux

//--- src/slot_control.sv
`timescale 1ns/100ps

module slot_control #(
   parameter int DB_GPIO_W = 32,
   parameter int FP_GPIO_W = 12
) (
   input  logic                                    radio_clk,
   input  logic                                    i_rst_n,
   input  logic                                    i_wr_stb,
   input  slot_regs_pkg::slot_reg_t                i_reg,
   input  logic [radio_cfg_pkg::APB_DATA_W-1:0]    i_wdata,
   output logic [radio_cfg_pkg::APB_DATA_W-1:0]    o_rdata,
   input  logic [radio_cfg_pkg::CHANS_PER_SLOT-1:0] i_rx_running,
   input  logic [radio_cfg_pkg::CHANS_PER_SLOT-1:0] i_tx_running,
   input  logic [DB_GPIO_W-1:0]                    i_db_gpio_in,
   output logic [DB_GPIO_W-1:0]                    o_db_gpio_out,
   output logic [DB_GPIO_W-1:0]                    o_db_gpio_ddr,
   input  logic [FP_GPIO_W-1:0]                    i_fp_gpio_in,
   output logic [FP_GPIO_W-1:0]                    o_fp_gpio_out,
   output logic [FP_GPIO_W-1:0]                    o_fp_gpio_ddr,
   output logic [radio_cfg_pkg::LED_W-1:0]         o_led,
   input  logic [radio_cfg_pkg::APB_DATA_W-1:0]    i_misc_in,
   output logic [radio_cfg_pkg::APB_DATA_W-1:0]    o_misc_out
);

   import radio_cfg_pkg::*;
   import slot_regs_pkg::*;

   atr_state_t            r_atr_state;
   logic                  w_db_wr;
   logic                  w_fp_wr;
   logic [2:0]            w_fp_sel;
   logic [DB_GPIO_W-1:0]  w_db_rb;
   logic [FP_GPIO_W-1:0]  w_fp_rb;
   logic [APB_DATA_W-1:0] r_misc_out;
   logic [APB_DATA_W-1:0] r_misc_in;

   // --------------------------------------------------
   // atr state from both channels
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         r_atr_state <= IDLE;
      end else begin
         r_atr_state <= atr_state_t'({|i_tx_running, |i_rx_running});
      end
   end

   // leds: rx only, any tx, full duplex
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_led <= '0;
      end else begin
         o_led <= {r_atr_state == RX_ONLY,
                   r_atr_state == TX_ONLY || r_atr_state == FULL_DUPLEX,
                   r_atr_state == FULL_DUPLEX};
      end
   end

   // --------------------------------------------------
   // gpio banks, db at 0-4, fp at 5-9
   // --------------------------------------------------
   assign w_db_wr  = i_wr_stb & (i_reg <= DB_DDR);
   assign w_fp_wr  = i_wr_stb & (i_reg >= FP_ATR_IDLE) & (i_reg <= FP_DDR);
   assign w_fp_sel = 3'(i_reg - FP_ATR_IDLE);   // rebase to 0-4

   db_gpio_atr #(.GPIO_W(DB_GPIO_W)) u_db_atr (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_wr_stb    (w_db_wr),
      .i_sel       (i_reg[2:0]),
      .i_wdata     (i_wdata[DB_GPIO_W-1:0]),
      .i_atr_state (r_atr_state),
      .o_gpio_out  (o_db_gpio_out),
      .o_gpio_ddr  (o_db_gpio_ddr),
      .o_rb        (w_db_rb)
   );

   db_gpio_atr #(.GPIO_W(FP_GPIO_W)) u_fp_atr (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_wr_stb    (w_fp_wr),
      .i_sel       (w_fp_sel),
      .i_wdata     (i_wdata[FP_GPIO_W-1:0]),
      .i_atr_state (r_atr_state),
      .o_gpio_out  (o_fp_gpio_out),
      .o_gpio_ddr  (o_fp_gpio_ddr),
      .o_rb        (w_fp_rb)
   );

   // --------------------------------------------------
   // misc registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         r_misc_out <= '0;
      end else if (i_wr_stb && i_reg == MISC_OUT) begin
         r_misc_out <= i_wdata;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         r_misc_in <= '0;
      end else begin
         r_misc_in <= i_misc_in;   // one input stage
      end
   end

   assign o_misc_out = r_misc_out;

   // readback, all 13 offsets
   always_comb begin
      case (i_reg)
         DB_ATR_IDLE, DB_ATR_RX, DB_ATR_TX, DB_ATR_FDX, DB_DDR:
            o_rdata = APB_DATA_W'(w_db_rb);
         FP_ATR_IDLE, FP_ATR_RX, FP_ATR_TX, FP_ATR_FDX:
            o_rdata = APB_DATA_W'(w_fp_rb);
         // front-panel pins sit just above the direction bits
         FP_DDR:     o_rdata = APB_DATA_W'({i_fp_gpio_in, w_fp_rb});
         MISC_OUT:   o_rdata = r_misc_out;
         DB_GPIO_RB: o_rdata = APB_DATA_W'(i_db_gpio_in);   // live pins
         MISC_IN_RB: o_rdata = r_misc_in;
         default:    o_rdata = '0;
      endcase
   end

endmodule : slot_control

//--- src/apb_slot_decoder.sv
`timescale 1ns/100ps

module apb_slot_decoder (
   input  logic                                   radio_clk,
   input  logic                                   i_rst_n,
   // apb slave side
   input  logic                                   i_psel,
   input  logic                                   i_penable,
   input  logic                                   i_pwrite,
   input  logic [radio_cfg_pkg::APB_ADDR_W-1:0]   i_paddr,
   input  logic [radio_cfg_pkg::APB_DATA_W-1:0]   i_pwdata,
   output logic [radio_cfg_pkg::APB_DATA_W-1:0]   o_prdata,
   output logic                                   o_pready,
   output logic                                   o_pslverr,
   // slot side
   input  logic [radio_cfg_pkg::NUM_SLOTS-1:0][radio_cfg_pkg::APB_DATA_W-1:0] i_slot_rdata,
   output logic [radio_cfg_pkg::NUM_SLOTS-1:0]    o_slot_wr_stb,
   output slot_regs_pkg::slot_reg_t               o_reg,
   output logic [radio_cfg_pkg::APB_DATA_W-1:0]   o_wdata,
   // global space
   input  logic [radio_cfg_pkg::APB_DATA_W-1:0]   i_fp_src_rdata,
   output logic                                   o_fp_src_wr_stb
);

   import radio_cfg_pkg::*;
   import slot_regs_pkg::*;

   logic [3:0] w_offset;
   logic       w_global;
   logic       w_slot;
   logic       w_bad_off;
   logic       w_ro_write;
   logic       w_err;
   logic       w_apb_acc;
   logic       w_wr_ok;
   logic       r_setup_done;   // previous cycle was a setup phase

   // --------------------------------------------------
   // address split and access checks
   // --------------------------------------------------
   assign w_offset = i_paddr[OFFSET_MSB:OFFSET_LSB];
   assign w_global = i_paddr[GLOBAL_BIT];
   assign w_slot   = i_paddr[SLOT_SEL_BIT];

   // global space holds FP_SRC only
   assign w_bad_off = w_global ? (w_offset != 4'(FP_SRC_OFFSET))
                               : (w_offset > MISC_IN_RB);

   // readback registers take no writes
   assign w_ro_write = ~w_global & i_pwrite &
                       ((w_offset == DB_GPIO_RB) || (w_offset == MISC_IN_RB));

   assign w_err = w_bad_off | w_ro_write;

   // --------------------------------------------------
   // apb handshake, no wait states
   // --------------------------------------------------
   assign w_apb_acc = i_psel & i_penable;
   assign o_pready  = w_apb_acc;
   assign o_pslverr = w_apb_acc & w_err;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         r_setup_done <= 1'b0;
      end else begin
         r_setup_done <= i_psel & ~i_penable;
      end
   end

   // write lands on the edge ending the access phase
   assign w_wr_ok = w_apb_acc & r_setup_done & i_pwrite & ~w_err;

   always_comb begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
         o_slot_wr_stb[s] = w_wr_ok & ~w_global & (int'(w_slot) == s);
      end
   end

   assign o_fp_src_wr_stb = w_wr_ok & w_global;
   assign o_reg           = slot_reg_t'(w_offset);  // shared by all slots
   assign o_wdata         = i_pwdata;

   // read mux, zero on error
   always_comb begin
      if (w_err) begin
         o_prdata = '0;
      end else if (w_global) begin
         o_prdata = i_fp_src_rdata;
      end else begin
         o_prdata = i_slot_rdata[w_slot];
      end
   end

endmodule : apb_slot_decoder

//--- src/db_gpio_atr.sv
`timescale 1ns/100ps

module db_gpio_atr #(
   parameter int GPIO_W = 32
) (
   input  logic                      radio_clk,
   input  logic                      i_rst_n,
   input  logic                      i_wr_stb,
   input  logic [2:0]                i_sel,      // 0-3 atr words, 4 ddr
   input  logic [GPIO_W-1:0]         i_wdata,
   input  slot_regs_pkg::atr_state_t i_atr_state,
   output logic [GPIO_W-1:0]         o_gpio_out,
   output logic [GPIO_W-1:0]         o_gpio_ddr,
   output logic [GPIO_W-1:0]         o_rb
);

   logic [GPIO_W-1:0] r_atr [4];   // indexed by atr state
   logic [GPIO_W-1:0] r_ddr;

   // --------------------------------------------------
   // register bank
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         for (int k = 0; k < 4; k++) begin
            r_atr[k] <= '0;
         end
         r_ddr <= '0;
      end else if (i_wr_stb) begin
         if (i_sel == 3'd4) begin
            r_ddr <= i_wdata;
         end else if (i_sel < 3'd4) begin
            r_atr[i_sel[1:0]] <= i_wdata;
         end
      end
   end

   // output word follows the state, one cycle behind
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;
      end else begin
         o_gpio_out <= r_atr[i_atr_state];
         o_gpio_ddr <= r_ddr;   // same latency as the data word
      end
   end

   // readback of the addressed word
   always_comb begin
      if (i_sel == 3'd4) begin
         o_rb = r_ddr;
      end else if (i_sel < 3'd4) begin
         o_rb = r_atr[i_sel[1:0]];
      end else begin
         o_rb = '0;
      end
   end

endmodule : db_gpio_atr

//--- src/slot_regs_pkg.sv
package slot_regs_pkg;

   // --------------------------------------------------
   // slot register map, offset = paddr[5:2]
   // --------------------------------------------------
   typedef enum logic [3:0] {
      DB_ATR_IDLE = 4'd0,   // db gpio word, idle
      DB_ATR_RX   = 4'd1,
      DB_ATR_TX   = 4'd2,
      DB_ATR_FDX  = 4'd3,
      DB_DDR      = 4'd4,   // db direction, 1 = output
      FP_ATR_IDLE = 4'd5,   // front-panel words, same order
      FP_ATR_RX   = 4'd6,
      FP_ATR_TX   = 4'd7,
      FP_ATR_FDX  = 4'd8,
      FP_DDR      = 4'd9,
      MISC_OUT    = 4'd10,
      DB_GPIO_RB  = 4'd11,  // read-only
      MISC_IN_RB  = 4'd12   // read-only
   } slot_reg_t;

   // bit 1 = tx active, bit 0 = rx active
   typedef enum logic [1:0] {
      IDLE        = 2'd0,
      RX_ONLY     = 2'd1,
      TX_ONLY     = 2'd2,
      FULL_DUPLEX = 2'd3
   } atr_state_t;

   // --------------------------------------------------
   // address fields
   // --------------------------------------------------
   localparam int OFFSET_LSB    = 2;
   localparam int OFFSET_MSB    = 5;
   localparam int SLOT_SEL_BIT  = 6;   // 0 = slot 0, 1 = slot 1
   localparam int GLOBAL_BIT    = 7;   // global space, slot bit ignored
   localparam int FP_SRC_OFFSET = 0;   // only global register

endpackage : slot_regs_pkg

//--- src/radio_cfg_pkg.sv
package radio_cfg_pkg;

   // --------------------------------------------------
   // slot and channel counts
   // --------------------------------------------------
   localparam int NUM_SLOTS      = 2;   // daughterboard slots
   localparam int CHANS_PER_SLOT = 2;   // run flags ORed per slot

   // --------------------------------------------------
   // register bus
   // --------------------------------------------------
   localparam int APB_ADDR_W = 12;      // byte address
   localparam int APB_DATA_W = 32;

   // --------------------------------------------------
   // gpio and led widths
   // --------------------------------------------------
   // defaults only, the top level can override the gpio widths
   localparam int DB_GPIO_W_DEF = 32;   // daughterboard gpio pins
   localparam int FP_GPIO_W_DEF = 12;   // front-panel gpio pins

   // led order, msb first: rx, txrx_tx, txrx_rx
   localparam int LED_W = 3;

endpackage : radio_cfg_pkg
